//--- ncu_link_pkg.sv
// MCU to NCU upstream link: beat geometry and the response opcodes carried in nibble 0
package ncu_link_pkg;

    // One beat carries a single nibble of the packet
    localparam int unsigned beat_width = 4;

    // A complete response packet is 32 beats long
    localparam int unsigned beats_per_packet = 32;

    // Selects one nibble slot within the packet
    localparam int unsigned beat_index_width = $clog2(beats_per_packet);

    // Holds 0 up to beats_per_packet + 1, the last value flags an overlong burst
    localparam int unsigned beat_count_width = 6;

    // Packet size as seen once all beats are assembled
    localparam int unsigned packet_width = beat_width * beats_per_packet;

    // The opcode is the first nibble on the wire
    localparam int unsigned opcode_width = 4;

    // Upstream response opcodes

    // Load return, no data
    localparam logic [opcode_width-1:0] op_read_nack = 4'b0000;

    // Load return with data
    localparam logic [opcode_width-1:0] op_read_ack = 4'b0001;

    // Instruction fill return with data
    localparam logic [opcode_width-1:0] op_ifill_ack = 4'b0011;

    // Instruction fill return, no data
    localparam logic [opcode_width-1:0] op_ifill_nack = 4'b0111;

    // Interrupt from the MCU
    localparam logic [opcode_width-1:0] op_int = 4'b1000;

    // Interrupt carrying a vector
    localparam logic [opcode_width-1:0] op_int_vec = 4'b1100;

endpackage

//--- ncu_mon_pkg.sv
// Upstream monitor types: packet word views, response kinds, buffer depth and counter width
package ncu_mon_pkg;

    import ncu_link_pkg::*;

    // Everything above the opcode nibble
    localparam int unsigned payload_width = packet_width - opcode_width;

    // One packet word, decoded either beat by beat or as opcode plus payload.
    // Nibble 0 arrives first and lands in bits 3:0, which is where the opcode lives.
    typedef union packed {
        logic [beats_per_packet-1:0][beat_width-1:0] nibbles;
        struct packed {
            logic [payload_width-1:0] payload;
            logic [opcode_width-1:0]  opcode;
        } fields;
    } mcu_packet_u;

    // Response kind handed out by the classifier
    localparam int unsigned kind_width = 3;

    localparam logic [kind_width-1:0] kind_read_nack  = 3'd0;
    localparam logic [kind_width-1:0] kind_read_ack   = 3'd1;
    localparam logic [kind_width-1:0] kind_ifill_ack  = 3'd2;
    localparam logic [kind_width-1:0] kind_ifill_nack = 3'd3;
    localparam logic [kind_width-1:0] kind_int        = 3'd4;
    localparam logic [kind_width-1:0] kind_int_vec    = 3'd5;

    // Packets held between the packer and the classifier
    localparam int unsigned fifo_depth = 4;

    localparam int unsigned fifo_ptr_width = $clog2(fifo_depth);

    // Occupancy must reach fifo_depth itself
    localparam int unsigned fifo_count_width = $clog2(fifo_depth + 1);

    // Error counters stick at all ones
    localparam int unsigned err_count_width = 8;

endpackage

//--- mcu_nibble_packer.sv
// Nibble packer that rebuilds 128-bit MCU responses from link beats and flags bad burst lengths
`timescale 1ns/100ps

module mcu_nibble_packer
(
    input  logic                                        iol2clk,
    input  logic                                        reset,
    input  logic                                        mcu_ncu_vld,
    input  logic [ncu_link_pkg::beat_width-1:0]         mcu_ncu_data,
    output logic                                        ncu_mcu_stall,
    output logic                                        pk_valid,
    input  logic                                        pk_ready,
    output ncu_mon_pkg::mcu_packet_u                    pk_packet,
    output logic [ncu_mon_pkg::err_count_width-1:0]     len_err_count
);

    import ncu_link_pkg::*;

    localparam logic [beat_count_width-1:0] full_count = beat_count_width'(beats_per_packet);
    localparam logic [beat_count_width-1:0] over_count = beat_count_width'(beats_per_packet + 1);

    logic [beat_count_width-1:0] beat_count;
    logic                        beat_taken;
    logic                        burst_end;
    logic                        burst_complete;

    // The link is held off only while a finished packet waits for buffer space
    assign ncu_mcu_stall = pk_valid && !pk_ready;

    assign beat_taken = mcu_ncu_vld && !ncu_mcu_stall;

    // A low vld closes the burst only after at least one beat, so idle cycles are ignored
    assign burst_end = !mcu_ncu_vld && (beat_count != '0);

    assign burst_complete = (beat_count == full_count);

    // Beat counter, packet handshake and length error count
    always_ff @(posedge iol2clk)
    begin
        if (reset)
        begin
            beat_count    <= '0;
            pk_valid      <= 1'b0;
            len_err_count <= '0;
        end
        else
        begin
            if (pk_valid && pk_ready)
            begin
                pk_valid <= 1'b0;
            end

            if (beat_taken)
            begin
                // Stops one past a full packet, which is enough to mark it too long
                if (beat_count != over_count)
                begin
                    beat_count <= beat_count + 1'b1;
                end
            end
            else if (burst_end)
            begin
                beat_count <= '0;
                if (burst_complete)
                begin
                    pk_valid <= 1'b1;
                end
                else if (len_err_count != '1)
                begin
                    len_err_count <= len_err_count + 1'b1;
                end
            end
        end
    end

    // Each beat goes to the nibble slot given by the count and extra beats are not stored.
    // The first beat of a new burst can only arrive at the edge that hands the old
    // packet over, so the shared word is never overwritten while it waits
    always_ff @(posedge iol2clk)
    begin
        if (beat_taken && (beat_count < full_count))
        begin
            pk_packet.nibbles[beat_count[beat_index_width-1:0]] <= mcu_ncu_data;
        end
    end

    // The count saturates one past a full packet
    assert property (@(posedge iol2clk) disable iff (reset)
        beat_count <= over_count);

endmodule

//--- packet_fifo.sv
// Circular packet buffer between the nibble packer and the response classifier
`timescale 1ns/100ps

module packet_fifo
(
    input  logic                     iol2clk,
    input  logic                     reset,
    input  logic                     pk_valid,
    output logic                     pk_ready,
    input  ncu_mon_pkg::mcu_packet_u pk_packet,
    output logic                     fb_valid,
    input  logic                     fb_ready,
    output ncu_mon_pkg::mcu_packet_u fb_packet
);

    import ncu_mon_pkg::*;

    localparam logic [fifo_count_width-1:0] full_level = fifo_count_width'(fifo_depth);

    mcu_packet_u                 mem [fifo_depth];
    logic [fifo_ptr_width-1:0]   wr_ptr;
    logic [fifo_ptr_width-1:0]   rd_ptr;
    logic [fifo_count_width-1:0] count;
    logic                        wr_en;
    logic                        rd_en;

    assign pk_ready = (count != full_level);
    assign fb_valid = (count != '0);

    // Reads come straight from the head entry
    assign fb_packet = mem[rd_ptr];

    assign wr_en = pk_valid && pk_ready;
    assign rd_en = fb_valid && fb_ready;

    // Pointer and occupancy update with the pointers wrapping at the depth
    always_ff @(posedge iol2clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_en)
            begin
                wr_ptr <= (wr_ptr == fifo_ptr_width'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en)
            begin
                rd_ptr <= (rd_ptr == fifo_ptr_width'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (wr_en && !rd_en)
            begin
                count <= count + 1'b1;
            end
            else if (rd_en && !wr_en)
            begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge iol2clk)
    begin
        if (wr_en)
        begin
            mem[wr_ptr] <= pk_packet;
        end
    end

    assert property (@(posedge iol2clk) disable iff (reset)
        count <= full_level);

    // A read needs an entry that the pointers also show as written
    assert property (@(posedge iol2clk) disable iff (reset)
        rd_en |-> ((rd_ptr != wr_ptr) || (count == full_level)));

endmodule

//--- mcu_rsp_classifier.sv
// Response classifier that maps the packet opcode to a kind code and registers the output stage
`timescale 1ns/100ps

module mcu_rsp_classifier
(
    input  logic                                     iol2clk,
    input  logic                                     reset,
    input  logic                                     fb_valid,
    output logic                                     fb_ready,
    input  ncu_mon_pkg::mcu_packet_u                 fb_packet,
    output logic                                     out_valid,
    input  logic                                     out_ready,
    output logic [ncu_mon_pkg::kind_width-1:0]       out_kind,
    output logic [ncu_mon_pkg::payload_width-1:0]    out_payload,
    output logic [ncu_mon_pkg::err_count_width-1:0]  bad_opcode_count
);

    import ncu_link_pkg::*;
    import ncu_mon_pkg::*;

    logic                  accept;
    logic                  known;
    logic [kind_width-1:0] kind;

    // Take a new packet when the output slot is free or drains this cycle
    assign fb_ready = !out_valid || out_ready;
    assign accept   = fb_valid && fb_ready;

    // Opcode decode
    always_comb
    begin
        known = 1'b1;
        kind  = kind_read_nack;
        case (fb_packet.fields.opcode)
            op_read_nack:  kind = kind_read_nack;
            op_read_ack:   kind = kind_read_ack;
            op_ifill_ack:  kind = kind_ifill_ack;
            op_ifill_nack: kind = kind_ifill_nack;
            op_int:        kind = kind_int;
            op_int_vec:    kind = kind_int_vec;
            default:       known = 1'b0;
        endcase
    end

    // Output valid and the bad opcode count
    always_ff @(posedge iol2clk)
    begin
        if (reset)
        begin
            out_valid        <= 1'b0;
            bad_opcode_count <= '0;
        end
        else
        begin
            if (out_valid && out_ready)
            begin
                out_valid <= 1'b0;
            end
            if (accept && known)
            begin
                out_valid <= 1'b1;
            end
            // Unknown opcodes are consumed and only counted
            if (accept && !known && (bad_opcode_count != '1))
            begin
                bad_opcode_count <= bad_opcode_count + 1'b1;
            end
        end
    end

    always_ff @(posedge iol2clk)
    begin
        if (accept && known)
        begin
            out_kind    <= kind;
            out_payload <= fb_packet.fields.payload;
        end
    end

    // A stalled result holds until the consumer takes it
    assert property (@(posedge iol2clk) disable iff (reset)
        (out_valid && !out_ready) |=>
            (out_valid && $stable(out_kind) && $stable(out_payload)));

endmodule

//--- ncu_mcu_upstream_mon.sv
// MCU to NCU upstream link monitor top that chains packer, packet buffer and classifier
`timescale 1ns/100ps

module ncu_mcu_upstream_mon
(
    input  logic                                     iol2clk,
    input  logic                                     reset,
    input  logic                                     mcu_ncu_vld,
    input  logic [ncu_link_pkg::beat_width-1:0]      mcu_ncu_data,
    output logic                                     ncu_mcu_stall,
    output logic                                     out_valid,
    input  logic                                     out_ready,
    output logic [ncu_mon_pkg::kind_width-1:0]       out_kind,
    output logic [ncu_mon_pkg::payload_width-1:0]    out_payload,
    output logic [ncu_mon_pkg::err_count_width-1:0]  len_err_count,
    output logic [ncu_mon_pkg::err_count_width-1:0]  bad_opcode_count
);

    import ncu_mon_pkg::*;

    // Packer to buffer
    logic        pk_valid;
    logic        pk_ready;
    mcu_packet_u pk_packet;

    // Buffer to classifier
    logic        fb_valid;
    logic        fb_ready;
    mcu_packet_u fb_packet;

    mcu_nibble_packer packer_i
    (
        .iol2clk       (iol2clk),
        .reset         (reset),
        .mcu_ncu_vld   (mcu_ncu_vld),
        .mcu_ncu_data  (mcu_ncu_data),
        .ncu_mcu_stall (ncu_mcu_stall),
        .pk_valid      (pk_valid),
        .pk_ready      (pk_ready),
        .pk_packet     (pk_packet),
        .len_err_count (len_err_count)
    );

    packet_fifo fifo_i
    (
        .iol2clk   (iol2clk),
        .reset     (reset),
        .pk_valid  (pk_valid),
        .pk_ready  (pk_ready),
        .pk_packet (pk_packet),
        .fb_valid  (fb_valid),
        .fb_ready  (fb_ready),
        .fb_packet (fb_packet)
    );

    mcu_rsp_classifier classifier_i
    (
        .iol2clk          (iol2clk),
        .reset            (reset),
        .fb_valid         (fb_valid),
        .fb_ready         (fb_ready),
        .fb_packet        (fb_packet),
        .out_valid        (out_valid),
        .out_ready        (out_ready),
        .out_kind         (out_kind),
        .out_payload      (out_payload),
        .bad_opcode_count (bad_opcode_count)
    );

endmodule

//--- tb_clock_gen.sv
// Testbench clock and reset source with a 40 ns clock and a reset held for the first cycles
`timescale 1ns/100ps

module tb_clock_gen
#(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 10
)
(
    output logic iol2clk,
    output logic reset
);

    initial
    begin
        iol2clk = 1'b0;
        forever #(period_ns / 2) iol2clk = ~iol2clk;
    end

    // Reset drops on a rising edge like any other driven input
    initial
    begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge iol2clk);
        reset <= 1'b0;
    end

endmodule

//--- tb_ncu_mcu_upstream_mon.sv
// Testbench for the upstream monitor that replays bursts from a data file and scores the results
`timescale 1ns/100ps

module tb_ncu_mcu_upstream_mon;

    import ncu_link_pkg::*;
    import ncu_mon_pkg::*;

    // Slack per burst on top of its beats
    localparam int cycles_per_burst = 40;

    logic                       iol2clk;
    logic                       reset;
    logic                       mcu_ncu_vld;
    logic [beat_width-1:0]      mcu_ncu_data;
    logic                       ncu_mcu_stall;
    logic                       out_valid;
    logic                       out_ready;
    logic [kind_width-1:0]      out_kind;
    logic [payload_width-1:0]   out_payload;
    logic [err_count_width-1:0] len_err_count;
    logic [err_count_width-1:0] bad_opcode_count;

    // One entry per burst line
    int                      beats_q[$];
    logic [packet_width-1:0] packet_q[$];
    logic [3:0]              code_q[$];

    // Results the DUT still owes, oldest first
    logic [kind_width-1:0]    exp_kind_q[$];
    logic [payload_width-1:0] exp_payload_q[$];

    int          mismatch_count = 0;
    int          other_count = 0;
    int          exp_len_errors = 0;
    int          exp_bad_opcodes = 0;
    int          cycle_limit = 0;
    int          cycle_count = 0;
    logic        data_loaded = 1'b0;
    logic        random_ready = 1'b0;
    logic [31:0] lfsr_state = 32'hbef2;
    logic        ready_bit;
    logic        loaded_ok;
    int          idx;
    int          step;

    tb_clock_gen clock_gen_i
    (
        .iol2clk (iol2clk),
        .reset   (reset)
    );

    ncu_mcu_upstream_mon dut_i
    (
        .iol2clk          (iol2clk),
        .reset            (reset),
        .mcu_ncu_vld      (mcu_ncu_vld),
        .mcu_ncu_data     (mcu_ncu_data),
        .ncu_mcu_stall    (ncu_mcu_stall),
        .out_valid        (out_valid),
        .out_ready        (out_ready),
        .out_kind         (out_kind),
        .out_payload      (out_payload),
        .len_err_count    (len_err_count),
        .bad_opcode_count (bad_opcode_count)
    );

    // Fibonacci LFSR with taps 32, 22, 2 and 1, the new bit enters at bit 0
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic kind_check(input logic [kind_width-1:0] expected,
                              input logic [kind_width-1:0] actual);
        if (actual !== expected)
        begin
            mismatch_count++;
            $display("mismatch at %0t: out_kind expected %h actual %h", $time, expected, actual);
        end
    endtask

    task automatic payload_check(input logic [payload_width-1:0] expected,
                                 input logic [payload_width-1:0] actual);
        if (actual !== expected)
        begin
            mismatch_count++;
            $display("mismatch at %0t: out_payload expected %h actual %h",
                     $time, expected, actual);
        end
    endtask

    task automatic count_check(input string name, input logic [err_count_width-1:0] expected,
                               input logic [err_count_width-1:0] actual);
        if (actual !== expected)
        begin
            mismatch_count++;
            $display("mismatch at %0t: %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    task automatic flag_check(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            mismatch_count++;
            $display("mismatch at %0t: %s expected %b actual %b", $time, name, expected, actual);
        end
    endtask

    task automatic load_testdata(output logic ok);
        int                      fd;
        int                      fields;
        int                      beats;
        logic [packet_width-1:0] packet;
        logic [3:0]              code;
        string                   line;
        fd = $fopen("ncu_mcu_upstream_mon_testdata.txt", "r");
        if (fd != 0)
        begin
            while ($fgets(line, fd) != 0)
            begin
                // Comment and blank lines carry no burst
                if (line.len() > 1 && line.getc(0) != "#")
                begin
                    fields = $sscanf(line, "%d %h %h", beats, packet, code);
                    if (fields == 3)
                    begin
                        beats_q.push_back(beats);
                        packet_q.push_back(packet);
                        code_q.push_back(code);
                        cycle_limit += beats + cycles_per_burst;
                    end
                    else
                    begin
                        other_count++;
                        $display("data file line could not be parsed: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
        ok = (beats_q.size() != 0);
    endtask

    // Kinds 0 to 5 are owed as results, e and b are drops that only count
    task automatic expect_burst(input int n);
        if (code_q[n] <= 4'd5)
        begin
            exp_kind_q.push_back(kind_width'(code_q[n]));
            exp_payload_q.push_back(packet_q[n][packet_width-1:opcode_width]);
        end
        else if (code_q[n] == 4'he)
            exp_len_errors++;
        else if (code_q[n] == 4'hb)
            exp_bad_opcodes++;
        else
        begin
            other_count++;
            $display("data line %0d has an unknown expected code %h", n, code_q[n]);
        end
    endtask

    // Nibble 0 goes first, a beat is held until the link shows no stall
    task automatic send_burst(input int beats, input logic [packet_width-1:0] packet);
        for (int i = 0; i < beats; i++)
        begin
            @(posedge iol2clk);
            mcu_ncu_vld  <= 1'b1;
            mcu_ncu_data <= packet[(i % beats_per_packet) * beat_width +: beat_width];
            @(negedge iol2clk);
            while (ncu_mcu_stall)
                @(negedge iol2clk);
        end
        @(posedge iol2clk);
        mcu_ncu_vld  <= 1'b0;
        mcu_ncu_data <= '0;
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    endtask

    initial
    begin
        mcu_ncu_vld  = 1'b0;
        mcu_ncu_data = '0;
        load_testdata(loaded_ok);
        if (!loaded_ok)
        begin
            other_count++;
            $display("test data file is missing or holds no bursts");
        end
        else
        begin
            data_loaded = 1'b1;
            @(negedge iol2clk);
            while (reset)
                @(negedge iol2clk);
            flag_check("ncu_mcu_stall", 1'b0, ncu_mcu_stall);
            flag_check("out_valid", 1'b0, out_valid);
            count_check("len_err_count", 0, len_err_count);
            count_check("bad_opcode_count", 0, bad_opcode_count);

            // The first line is a lone burst into an idle pipeline with out_ready high
            if (beats_q[0] != beats_per_packet || code_q[0] > 4'd5)
            begin
                other_count++;
                $display("first data line is not a complete known packet for the latency check");
            end
            expect_burst(0);
            send_burst(beats_q[0], packet_q[0]);
            @(posedge iol2clk);
            for (step = 1; step <= 3; step++)
            begin
                @(negedge iol2clk);
                flag_check("out_valid", step == 3, out_valid);
            end
            random_ready = 1'b1;

            for (idx = 1; idx < beats_q.size(); idx++)
            begin
                expect_burst(idx);
                send_burst(beats_q[idx], packet_q[idx]);
            end
            @(posedge iol2clk);
            while (exp_kind_q.size() != 0)
                @(negedge iol2clk);
            // Drops behind the last result still need a few cycles to be counted
            repeat (8) @(negedge iol2clk);
            count_check("len_err_count", exp_len_errors, len_err_count);
            count_check("bad_opcode_count", exp_bad_opcodes, bad_opcode_count);
        end
        finish_run();
    end

    // Output back-pressure, ready only when five fresh LFSR bits are all one
    initial
    begin
        out_ready = 1'b1;
        forever
        begin
            @(posedge iol2clk);
            if (random_ready)
            begin
                ready_bit = 1'b1;
                for (int b = 0; b < 5; b++)
                begin
                    lfsr_state = lfsr_step(lfsr_state);
                    ready_bit  = ready_bit & lfsr_state[0];
                end
                out_ready <= ready_bit;
            end
            else
                out_ready <= 1'b1;
        end
    end

    // A result moves at the next rising edge when valid and ready are both high
    always @(negedge iol2clk)
    begin
        if (!reset && out_valid && out_ready)
        begin
            if (exp_kind_q.size() == 0)
            begin
                other_count++;
                $display("unexpected result at %0t with no packet outstanding", $time);
            end
            else
            begin
                kind_check(exp_kind_q.pop_front(), out_kind);
                payload_check(exp_payload_q.pop_front(), out_payload);
            end
        end
    end

    initial
    begin
        wait (data_loaded);
        while (cycle_count < cycle_limit)
        begin
            @(posedge iol2clk);
            cycle_count++;
        end
        other_count++;
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        finish_run();
    end

endmodule

//--- ncu_mcu_upstream_mon_testdata.txt
# beats (decimal), packet (hex, last digit is nibble 0 and holds the opcode), expected result
# expected result: kind code 0 to 5, e for a length error drop, b for a bad opcode drop
32 0123456789abcdeffedcba9876543211 1
32 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a0 0
32 00000000000000000000000000000003 2
32 ffffffffffffffffffffffffffffff07 3
32 13579bdf02468ace13579bdf02468ac8 4
32 deadbeefcafef00d0123456789abcdec 5
31 11111111111111111111111111111111 e
33 22222222222222222222222222222221 e
32 3333333333333333333333333333333f b
32 0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f02 b
1 44444444444444444444444444444440 e
32 89abcdef0123456789abcdef01234561 1
32 fedcba9876543210fedcba9876543210 0
40 55555555555555555555555555555558 e
32 6666666666666666666666666666666c 5
32 77777777777777777777777777777774 b
32 8badf00d8badf00d8badf00d8badf003 2
32 0000000000000000000000000000000a b
32 c0ffee00c0ffee00c0ffee00c0ffee07 3
20 99999999999999999999999999999993 e
32 1234567890abcdef1234567890abcde8 4
32 aaaaaaaaaaaaaaaaaaaaaaaaaaaaaaa1 1
32 cccccccccccccccccccccccccccccccd b
32 dddddddddddddddddddddddddddddddc 5

//--- ncu_mcu_upstream_mon.f
ncu_link_pkg.sv
ncu_mon_pkg.sv
mcu_nibble_packer.sv
packet_fifo.sv
mcu_rsp_classifier.sv
ncu_mcu_upstream_mon.sv
tb_clock_gen.sv
tb_ncu_mcu_upstream_mon.sv

//--- Bender.yml
package:
  name: ncu_mcu_upstream_mon

sources:
  - ncu_link_pkg.sv
  - ncu_mon_pkg.sv
  - mcu_nibble_packer.sv
  - packet_fifo.sv
  - mcu_rsp_classifier.sv
  - ncu_mcu_upstream_mon.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_ncu_mcu_upstream_mon.sv
